//--- Makefile
VERILATOR ?= verilator
TOP       ?= mem_subsystem_tb
FILELIST  ?= mem_subsystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard verilog/*.sv verilog/*.svh test/*.sv)
BIN  := $(BUILD_DIR)/$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- mem_subsystem.f
+incdir+verilog
verilog/mem_pkg.sv
verilog/mem_req_queue.sv
verilog/mem_bank.sv
verilog/mem_init_seq.sv
verilog/mem_subsystem.sv
test/tb_clock_gen.sv
test/mem_subsystem_tb.sv

//--- test/mem_subsystem_tb.sv
`timescale 1ns/1ns
`include "mem_consts.svh"

module mem_subsystem_tb;

  localparam int num_ch_lp      = `MEM_NUM_CHANNELS;
  localparam int num_words_lp   = 2**`MEM_LOCAL_ADDR_WIDTH;
  localparam int period_ns_lp   = 100;
  localparam int random_cycles  = 400;
  // cycle estimates per test, watchdog allows twice the sum
  localparam int len_order      = num_words_lp + 60;
  localparam int len_counter    = 40;
  localparam int len_zero       = 3*num_words_lp + 40;
  localparam int len_merge      = 200;
  localparam int len_isolation  = 80;
  localparam int len_random     = random_cycles + 60;
  localparam int total_cycles   = len_order + len_counter + len_zero + len_merge
                                  + len_isolation + len_random;
  localparam longint timeout_ns = 2 * total_cycles * period_ns_lp;

  logic                      clk_i;
  logic                      reset_i;
  logic [num_ch_lp-1:0]      req_valid_i;
  mem_pkg::mem_req_s         req_i [num_ch_lp];
  logic [num_ch_lp-1:0]      credit_o;
  logic [num_ch_lp-1:0]      resp_valid_o;
  mem_pkg::mem_resp_s        resp_o [num_ch_lp];
  logic                      ready_o;
  logic [31:0]               cycle_count_o;

  int                        credits [num_ch_lp];
  int                        credit_pulses [num_ch_lp];
  int                        sent [num_ch_lp];
  mem_pkg::mem_data_t        ref_mem [num_ch_lp][num_words_lp];
  mem_pkg::mem_resp_s        exp_q [num_ch_lp][$];

  tb_clock_gen #(.period_ns_p(period_ns_lp)) clock (.clk_o(clk_i));

  mem_subsystem UUT (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .credit_o     (credit_o),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o),
    .ready_o      (ready_o),
    .cycle_count_o(cycle_count_o)
  );

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on first failure");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected)
      stop_with_failure($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected));
  endtask

  function automatic mem_pkg::mem_data_t byte_merge(input mem_pkg::mem_data_t old_w,
                                                    input mem_pkg::mem_data_t new_w,
                                                    input mem_pkg::mem_strb_t strb);
    mem_pkg::mem_data_t mask;
    for (int b = 0; b < `MEM_DATA_WIDTH/8; b++)
      mask[8*b +: 8] = {8{strb[b]}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  // new cycle, drop last cycle's valids
  task automatic next_cycle();
    @(posedge clk_i);
    req_valid_i <= '0;
  endtask

  // drive one request in the current cycle, record the expected response
  task automatic issue(input int ch, input logic wr, input mem_pkg::mem_local_addr_t a,
                       input mem_pkg::mem_data_t d, input mem_pkg::mem_strb_t s);
    mem_pkg::mem_req_s  r;
    mem_pkg::mem_resp_s e;
    logic [`MEM_SEL_WIDTH-1:0] sel;
    if (credits[ch] <= 0)
      stop_with_failure($sformatf("channel %0d would send without a credit", ch));
    sel     = (`MEM_SEL_WIDTH)'(ch);
    r.write = wr;
    r.addr  = a;
    r.data  = d;
    r.strb  = s;
    e.write = wr;
    e.addr  = {sel, a};
    e.data  = wr ? byte_merge(ref_mem[ch][a], d, s) : ref_mem[ch][a];
    if (wr)
      ref_mem[ch][a] = e.data;
    exp_q[ch].push_back(e);
    credits[ch]--;
    sent[ch]++;
    req_valid_i[ch] <= 1'b1;
    req_i[ch]       <= r;
  endtask

  task automatic send_one(input int ch, input logic wr, input mem_pkg::mem_local_addr_t a,
                          input mem_pkg::mem_data_t d, input mem_pkg::mem_strb_t s);
    next_cycle();
    while (credits[ch] == 0)
      next_cycle();
    issue(ch, wr, a, d, s);
  endtask

  task automatic wait_ready();
    int  n;
    bit  up;
    n  = 0;
    up = 0;
    while (!up) begin
      @(negedge clk_i);
      up = (ready_o === 1'b1);
      if (!up)
        check_value("cycle_count_o", 64'(cycle_count_o), 64'd0);  // held until release
      n++;
      if (!up && n > num_words_lp + 40)
        stop_with_failure("ready_o did not rise after reset");
    end
  endtask

  // all responses in and all credits back
  task automatic wait_drain(input int limit);
    int n;
    bit busy;
    n    = 0;
    busy = 1;
    while (busy) begin
      next_cycle();
      busy = 0;
      for (int c = 0; c < num_ch_lp; c++)
        if (exp_q[c].size() != 0 || credits[c] != `MEM_QUEUE_DEPTH) busy = 1;
      n++;
      if (busy && n > limit)
        stop_with_failure("responses or credits did not come back in time");
    end
  endtask

  always @(negedge clk_i) begin : monitor
    mem_pkg::mem_resp_s exp_r;
    if (!reset_i) begin
      for (int c = 0; c < num_ch_lp; c++) begin
        if (credit_o[c]) begin
          if (ready_o !== 1'b1)
            stop_with_failure($sformatf("credit returned on channel %0d before ready", c));
          credits[c]++;
          credit_pulses[c]++;
          if (credits[c] > `MEM_QUEUE_DEPTH)
            stop_with_failure($sformatf("channel %0d returned more credits than sent", c));
        end
        if (resp_valid_o[c]) begin
          if (exp_q[c].size() == 0)
            stop_with_failure($sformatf("unexpected response on channel %0d", c));
          exp_r = exp_q[c].pop_front();
          check_value($sformatf("resp_o[%0d].write", c), 64'(resp_o[c].write), 64'(exp_r.write));
          check_value($sformatf("resp_o[%0d].addr", c), 64'(resp_o[c].addr), 64'(exp_r.addr));
          check_value($sformatf("resp_o[%0d].data", c), 64'(resp_o[c].data), 64'(exp_r.data));
        end
      end
    end
  end

  // reads queued before release, answered in order once ready
  task automatic test_order_before_ready();
    for (int i = 0; i < `MEM_QUEUE_DEPTH; i++) begin
      next_cycle();
      issue(0, 1'b0, mem_pkg::mem_local_addr_t'(8'h20 + i), '0, '0);
    end
    next_cycle();
    wait_ready();
    // nothing answered while held
    check_value("pending responses[0]", 64'(exp_q[0].size()), 64'(`MEM_QUEUE_DEPTH));
    wait_drain(len_order);
    check_value("credit_pulses[0]", 64'(credit_pulses[0]), 64'(sent[0]));
  endtask

  task automatic test_init_and_counter();
    logic [31:0] c0;
    int          idx [num_ch_lp];
    bit          busy;
    @(negedge clk_i);
    c0 = cycle_count_o;
    repeat (10) @(negedge clk_i);
    check_value("cycle_count_o delta", 64'(cycle_count_o - c0), 64'd10);
    for (int c = 0; c < num_ch_lp; c++)
      idx[c] = 0;
    busy = 1;
    while (busy) begin
      next_cycle();
      busy = 0;
      for (int c = 0; c < num_ch_lp; c++) begin
        if (idx[c] < num_words_lp) begin
          busy = 1;
          if (credits[c] > 0) begin
            issue(c, 1'b0, mem_pkg::mem_local_addr_t'(idx[c]), '0, '0);
            idx[c]++;
          end
        end
      end
    end
    wait_drain(len_zero);
  endtask

  task automatic test_write_merge();
    mem_pkg::mem_local_addr_t a;
    for (int c = 0; c < num_ch_lp; c++) begin
      a = mem_pkg::mem_local_addr_t'(8'h10 + c);
      send_one(c, 1'b1, a, 32'h1122_3344, 4'hf);
      send_one(c, 1'b0, a, '0, '0);
      send_one(c, 1'b1, a, 32'haabb_ccdd, 4'b0101);  // partial
      send_one(c, 1'b0, a, '0, '0);
      send_one(c, 1'b1, a, 32'h5566_7788, 4'b1000);
      send_one(c, 1'b0, a, '0, '0);
    end
    wait_drain(len_merge);
  endtask

  task automatic test_channel_isolation();
    for (int c = 0; c < num_ch_lp; c++)
      send_one(c, 1'b1, 8'h5a, 32'hc0de_0000 | 32'(c), 4'hf);
    for (int c = 0; c < num_ch_lp; c++)
      send_one(c, 1'b0, 8'h5a, '0, '0);
    wait_drain(len_isolation);
  endtask

  // small address window so reads hit recent writes
  task automatic test_random_traffic();
    repeat (random_cycles) begin
      next_cycle();
      for (int c = 0; c < num_ch_lp; c++) begin
        if (credits[c] > 0 && $urandom_range(1, 0) == 1)
          issue(c, 1'($urandom), mem_pkg::mem_local_addr_t'($urandom_range(15, 0)),
                $urandom, mem_pkg::mem_strb_t'($urandom));
      end
    end
    wait_drain(len_random);
  endtask

  initial begin
    #(timeout_ns);
    stop_with_failure("watchdog expired before the tests finished");
  end

  initial begin
    void'($urandom(53804));
    reset_i     = 1'b1;
    req_valid_i = '0;
    for (int c = 0; c < num_ch_lp; c++) begin
      req_i[c]         = '0;
      credits[c]       = `MEM_QUEUE_DEPTH;
      credit_pulses[c] = 0;
      sent[c]          = 0;
      for (int w = 0; w < num_words_lp; w++)
        ref_mem[c][w] = '0;  // zero fill after reset
    end
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    test_order_before_ready();
    test_init_and_counter();
    test_write_merge();
    test_channel_isolation();
    test_random_traffic();
    for (int c = 0; c < num_ch_lp; c++)
      check_value($sformatf("credit_pulses[%0d]", c), 64'(credit_pulses[c]), 64'(sent[c]));
    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int period_ns_p = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(period_ns_p/2) clk_o = ~clk_o;  // free running
  end

endmodule

//--- verilog/mem_bank.sv
`timescale 1ns/1ns
`include "mem_consts.svh"

module mem_bank #(
  parameter int channel_id_p = 0
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     ready_i,
  input  logic                     empty_i,
  input  mem_pkg::mem_req_s        head_i,
  output logic                     pop_o,
  input  logic                     init_we_i,
  input  mem_pkg::mem_local_addr_t init_addr_i,
  output logic                     resp_valid_o,
  output mem_pkg::mem_resp_s       resp_o
);

  localparam int num_words_lp = 2**`MEM_LOCAL_ADDR_WIDTH;
  localparam int num_bytes_lp = `MEM_DATA_WIDTH/8;
  localparam logic [`MEM_SEL_WIDTH-1:0] sel_lp = (`MEM_SEL_WIDTH)'(channel_id_p);

  mem_pkg::mem_data_t mem_r [num_words_lp];
  mem_pkg::mem_data_t old_word;
  mem_pkg::mem_data_t merged_word;
  logic               resp_valid_r;
  mem_pkg::mem_resp_s resp_r;

  assign pop_o    = ready_i & ~empty_i;
  assign old_word = mem_r[head_i.addr];

  // byte merge under strobes
  always_comb begin
    merged_word = old_word;
    for (int b = 0; b < num_bytes_lp; b++) begin
      if (head_i.strb[b])
        merged_word[8*b +: 8] = head_i.data[8*b +: 8];
    end
  end

  always_ff @(posedge clk_i) begin
    if (init_we_i)
      mem_r[init_addr_i] <= '0;  // zero fill
    else if (pop_o && head_i.write)
      mem_r[head_i.addr] <= merged_word;
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      resp_r.write <= head_i.write;
      resp_r.addr  <= {sel_lp, head_i.addr};
      resp_r.data  <= head_i.write ? merged_word : old_word;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i)
      resp_valid_r <= 1'b0;
    else
      resp_valid_r <= pop_o;  // one cycle after the pop
  end

  assign resp_valid_o = resp_valid_r;
  assign resp_o       = resp_r;

  // init writes finish before traffic starts
  a_no_init_when_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    ready_i |-> !init_we_i);

endmodule

//--- verilog/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// channel layout
`define MEM_NUM_CHANNELS 4
`define MEM_SEL_WIDTH 2

// word and address sizes
`define MEM_DATA_WIDTH 32
`define MEM_LOCAL_ADDR_WIDTH 8

// per channel request buffering, also the starting credit count
`define MEM_QUEUE_DEPTH 4

// flops between end of zero fill and ready
`define MEM_RELEASE_DEPTH 3

`endif

//--- verilog/mem_init_seq.sv
`timescale 1ns/1ns
`include "mem_consts.svh"

module mem_init_seq (
  input  logic                     clk_i,
  input  logic                     reset_i,
  output logic                     init_we_o,
  output mem_pkg::mem_local_addr_t init_addr_o,
  output logic                     ready_o
);

  mem_pkg::mem_init_state_e state_r;
  mem_pkg::mem_local_addr_t addr_r;
  logic [`MEM_RELEASE_DEPTH-1:0] release_r;
  logic                          fill_done;

  assign fill_done = (state_r == mem_pkg::s_release) || (state_r == mem_pkg::s_done);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= mem_pkg::s_idle;
      addr_r  <= '0;
    end else begin
      case (state_r)
        mem_pkg::s_idle: state_r <= mem_pkg::s_fill;
        mem_pkg::s_fill: begin
          addr_r <= addr_r + 1'b1;
          if (addr_r == '1)
            state_r <= mem_pkg::s_release;  // last word written
        end
        mem_pkg::s_release: begin
          if (release_r[`MEM_RELEASE_DEPTH-1])
            state_r <= mem_pkg::s_done;
        end
        default: state_r <= mem_pkg::s_done;
      endcase
    end
  end

  // done bit walks the chain, msb is ready
  always_ff @(posedge clk_i) begin
    if (reset_i)
      release_r <= '0;
    else
      release_r <= {release_r[`MEM_RELEASE_DEPTH-2:0], fill_done};
  end

  assign init_we_o   = (state_r == mem_pkg::s_fill);
  assign init_addr_o = addr_r;
  assign ready_o     = release_r[`MEM_RELEASE_DEPTH-1];

endmodule

//--- verilog/mem_pkg.sv
`include "mem_consts.svh"

package mem_pkg;

  typedef logic [`MEM_DATA_WIDTH-1:0] mem_data_t;
  typedef logic [`MEM_LOCAL_ADDR_WIDTH-1:0] mem_local_addr_t;
  typedef logic [`MEM_SEL_WIDTH+`MEM_LOCAL_ADDR_WIDTH-1:0] mem_global_addr_t; // {sel, local}
  typedef logic [`MEM_DATA_WIDTH/8-1:0] mem_strb_t;

  // one word per request
  typedef struct packed {
    logic            write;
    mem_local_addr_t addr;
    mem_data_t       data;
    mem_strb_t       strb;
  } mem_req_s;

  typedef struct packed {
    logic             write;
    mem_global_addr_t addr;
    mem_data_t        data;  // read data, or stored word on a write
  } mem_resp_s;

  // zero fill, then release chain
  typedef enum logic [1:0] {
    s_idle,
    s_fill,
    s_release,
    s_done
  } mem_init_state_e;

endpackage

//--- verilog/mem_req_queue.sv
`timescale 1ns/1ns
`include "mem_consts.svh"

module mem_req_queue (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              req_valid_i,
  input  mem_pkg::mem_req_s req_i,
  input  logic              pop_i,
  output logic              empty_o,
  output mem_pkg::mem_req_s head_o,
  output logic              credit_o
);

  localparam int ptr_width_lp = $clog2(`MEM_QUEUE_DEPTH);

  mem_pkg::mem_req_s entries_r [`MEM_QUEUE_DEPTH];
  logic [ptr_width_lp-1:0] wr_ptr_r;
  logic [ptr_width_lp-1:0] rd_ptr_r;
  logic [ptr_width_lp:0]   count_r;
  logic                    full;
  logic                    push;
  logic                    pop;
  logic                    credit_r;

  assign full    = (count_r == (ptr_width_lp+1)'(`MEM_QUEUE_DEPTH));
  assign empty_o = (count_r == '0);
  assign push    = req_valid_i & ~full;
  assign pop     = pop_i & ~empty_o;
  assign head_o  = entries_r[rd_ptr_r];

  always_ff @(posedge clk_i) begin
    if (push)
      entries_r[wr_ptr_r] <= req_i;
  end

  // depth is a power of two, pointers wrap on their own
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
      credit_r <= 1'b0;
    end else begin
      if (push) wr_ptr_r <= wr_ptr_r + 1'b1;
      if (pop)  rd_ptr_r <= rd_ptr_r + 1'b1;
      case ({push, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
      credit_r <= pop;  // one credit back per entry handed out
    end
  end

  assign credit_o = credit_r;

  // requester sent without a credit
  a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    req_valid_i |-> !full)
    else $error("request pushed into full queue");

  a_no_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
    pop_i |-> !empty_o)
    else $error("pop from empty queue");

endmodule

//--- verilog/mem_subsystem.sv
`timescale 1ns/1ns
`include "mem_consts.svh"

module mem_subsystem (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic [`MEM_NUM_CHANNELS-1:0] req_valid_i,
  input  mem_pkg::mem_req_s            req_i [`MEM_NUM_CHANNELS],
  output logic [`MEM_NUM_CHANNELS-1:0] credit_o,
  output logic [`MEM_NUM_CHANNELS-1:0] resp_valid_o,
  output mem_pkg::mem_resp_s           resp_o [`MEM_NUM_CHANNELS],
  output logic                         ready_o,
  output logic [31:0]                  cycle_count_o
);

  logic                     init_we;
  mem_pkg::mem_local_addr_t init_addr;
  logic                     ready;
  logic [31:0]              cycle_count_r;

  mem_init_seq init_seq (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .init_we_o  (init_we),
    .init_addr_o(init_addr),
    .ready_o    (ready)
  );

  for (genvar i = 0; i < `MEM_NUM_CHANNELS; i++) begin : ch
    mem_pkg::mem_req_s head;
    logic              empty;
    logic              pop;

    mem_req_queue queue (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .req_valid_i(req_valid_i[i]),
      .req_i      (req_i[i]),
      .pop_i      (pop),
      .empty_o    (empty),
      .head_o     (head),
      .credit_o   (credit_o[i])
    );

    mem_bank #(
      .channel_id_p(i)
    ) bank (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .ready_i     (ready),
      .empty_i     (empty),
      .head_i      (head),
      .pop_o       (pop),
      .init_we_i   (init_we),
      .init_addr_i (init_addr),
      .resp_valid_o(resp_valid_o[i]),
      .resp_o      (resp_o[i])
    );
  end

  // global cycle counter, runs once channels are released
  always_ff @(posedge clk_i) begin
    if (reset_i || !ready)
      cycle_count_r <= '0;
    else
      cycle_count_r <= cycle_count_r + 1'b1;
  end

  assign ready_o       = ready;
  assign cycle_count_o = cycle_count_r;

endmodule
